// File: project.f
+incdir+verif
verilog/fe_pkg.sv
verilog/fe_cfg_if.sv
verilog/fe_regs.sv
verilog/adc_capture.sv
verilog/dac_format.sv
verilog/spi_router.sv
verilog/fe_top.sv
verif/tb_fe_top.sv

// File: Makefile
SIM := obj_dir/Vtb_fe_top

all: run

$(SIM): project.f $(wildcard verilog/*.sv verif/*.sv verif/*.svh)
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_fe_top -f project.f

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "^Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: verif/tb_fe_checks.svh
// Testbench helpers
`ifndef TB_FE_CHECKS_SVH
`define TB_FE_CHECKS_SVH

logic [31:0] lcg_state = 32'hbeb2_41b1;

function automatic logic [31:0] lcg_next();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return lcg_state;
endfunction

// Rising edge plus input skew
task automatic next_cycle();
   @(posedge dsp_clk);
   #1;
endtask

task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
                         output logic err);
   next_cycle();
   paddr_i  = addr;       // Setup phase
   pwrite_i = 1'b1;
   pwdata_i = data;
   psel_i   = 1'b1;
   next_cycle();
   penable_i = 1'b1;
   #1;
   err = pslverr_o;
   next_cycle();          // Write lands on this edge
   psel_i    = 1'b0;
   penable_i = 1'b0;
endtask

task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
                        output logic err);
   next_cycle();
   paddr_i  = addr;
   pwrite_i = 1'b0;
   psel_i   = 1'b1;
   next_cycle();
   penable_i = 1'b1;
   #1;
   data = prdata_o;       // Valid in the access phase
   err  = pslverr_o;
   next_cycle();
   psel_i    = 1'b0;
   penable_i = 1'b0;
endtask

task automatic check_adc(input string name, input adc_sample_t exp, input adc_sample_t act);
   if (act !== exp)
   begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      abort_run();
   end
endtask

task automatic check_dac(input string name, input dac_sample_t exp, input dac_sample_t act);
   if (act !== exp)
   begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      abort_run();
   end
endtask

task automatic check_sen(input string name, input spi_sen_t exp, input spi_sen_t act);
   if (act !== exp)
   begin
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
      abort_run();
   end
endtask

task automatic check_led(input string name, input led_t exp, input led_t act);
   if (act !== exp)
   begin
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
      abort_run();
   end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
   if (act !== exp)
   begin
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
      abort_run();
   end
endtask

`endif

// File: verif/tb_fe_top.sv
`timescale 1ns/1ps
// Front-end adapter testbench

module tb_fe_top;
   import fe_pkg::*;

   localparam int N_REG = 4;
   localparam int N_ERR = 4;
   localparam int N_PAR = 16;
   localparam int N_IQ  = 6;
   localparam int N_SPI = 5;
   localparam int TIMEOUT_CYCLES =
      2 * (8 + 12 * N_REG + 3 * N_ERR + 2 * N_PAR + 4 * N_IQ + 20 + 7 * N_SPI);

   // Board LED polarity and MISO wiring
   localparam led_t     LED_ACTIVE_LOW = 6'b011111;
   localparam spi_sen_t MISO_PRESENT   = 9'b1_0110_1011;   // No adc, tx_dac, rx_dac

   localparam led_t     LED_TAB [N_REG] = '{6'h00, 6'h3f, 6'h2a, 6'h21};
   localparam spi_sen_t SEN_TAB [N_REG] = '{9'h1ff, 9'h000, 9'h155, 9'h0f3};
   // Writes to read-only and unmapped addresses, one good read
   localparam logic [APB_AW-1:0] ERR_ADDR [N_ERR] = '{8'h0C, 8'h10, 8'h14, 8'h20};
   localparam logic ERR_WR  [N_ERR] = '{1'b1, 1'b0, 1'b1, 1'b0};
   localparam logic ERR_EXP [N_ERR] = '{1'b1, 1'b0, 1'b1, 1'b1};
   localparam logic [LMS_W-1:0] IQ_I [N_IQ] =
      '{12'h000, 12'hfff, 12'h123, 12'h800, 12'h5a5, 12'h07f};
   localparam logic [LMS_W-1:0] IQ_Q [N_IQ] =
      '{12'hfff, 12'h000, 12'hcba, 12'h001, 12'ha5a, 12'hf80};
   localparam spi_sen_t SPI_SEN_TAB  [N_SPI] = '{9'h1ff, 9'h1fe, 9'h1fb, 9'h000, 9'h0aa};
   localparam spi_sen_t SPI_MISO_TAB [N_SPI] = '{9'h1ff, 9'h001, 9'h004, 9'h094, 9'h155};

   logic                 dsp_clk;
   logic                 rst_i;
   logic [APB_AW-1:0]    paddr_i;
   logic                 psel_i;
   logic                 penable_i;
   logic                 pwrite_i;
   logic [APB_DW-1:0]    pwdata_i;
   logic [APB_DW-1:0]    prdata_o;
   logic                 pready_o;
   logic                 pslverr_o;
   led_t                 leds_o;
   adc_sample_t          adc_a_pins_i;
   adc_sample_t          adc_b_pins_i;
   logic [LMS_W-1:0]     lms_adc_i;
   logic                 rx_iq_sel_o;
   adc_sample_t          adc_a_o;
   adc_sample_t          adc_b_o;
   logic                 adc_valid_o;
   dac_sample_t          dac_a_i;
   dac_sample_t          dac_b_i;
   dac_sample_t          dac_a_o;
   dac_sample_t          dac_b_o;
   logic [LMS_W-1:0]     lms_dac_o;
   logic                 tx_iq_sel_o;
   logic                 sclk_i;
   logic                 mosi_i;
   logic [SPI_DEV_N-1:0] spi_miso_i;
   spi_sen_t             spi_sen_o;
   spi_sen_t             spi_sclk_o;
   spi_sen_t             spi_mosi_o;
   logic                 miso_o;

   adc_sample_t pin_a [N_PAR];
   adc_sample_t pin_b [N_PAR];
   adc_sample_t exp_a [N_PAR];
   dac_sample_t dac_a_tab [N_PAR];
   dac_sample_t dac_b_tab [N_PAR];
   logic [31:0]       rnd;
   logic [APB_DW-1:0] rdata;
   logic              err;
   int                cycle_cnt = 0;

   fe_top u_dut (.*);

   `include "tb_fe_checks.svh"

   task automatic abort_run();
      $display("Result: FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   // A peripheral line follows v only while its select is low
   function automatic spi_sen_t gated(input spi_sen_t sen, input logic v);
      spi_sen_t r;
      r = '0;
      for (int d = 0; d < SPI_DEV_N; d++)
         r[d] = sen[d] ? 1'b0 : v;
      return r;
   endfunction

   function automatic logic miso_sel(input spi_sen_t sen, input spi_sen_t miso);
      logic r;
      r = 1'b0;
      for (int d = 0; d < SPI_DEV_N; d++)
         if (!sen[d] && MISO_PRESENT[d] && miso[d])
            r = 1'b1;
      return r;
   endfunction

   initial
   begin
      dsp_clk = 1'b0;
      forever #2 dsp_clk = ~dsp_clk;   // 4 ns
   end

   always @(posedge dsp_clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == TIMEOUT_CYCLES)
      begin
         $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         abort_run();
      end
   end

   initial
   begin
      rst_i        = 1'b1;
      paddr_i      = '0;
      psel_i       = 1'b0;
      penable_i    = 1'b0;
      pwrite_i     = 1'b0;
      pwdata_i     = '0;
      adc_a_pins_i = '0;
      adc_b_pins_i = '0;
      lms_adc_i    = '0;
      dac_a_i      = '0;
      dac_b_i      = '0;
      sclk_i       = 1'b0;
      mosi_i       = 1'b0;
      spi_miso_i   = '0;

      for (int i = 0; i < N_PAR; i++)
      begin
         rnd       = lcg_next();
         pin_a[i]  = rnd[ADC_W-1:0];
         pin_b[i]  = rnd[31:32-ADC_W];
         exp_a[i]  = ~pin_a[i];          // A inverted on the board
         rnd       = lcg_next();
         dac_a_tab[i] = rnd[15:0];
         dac_b_tab[i] = rnd[31:16];
      end

      repeat (8) @(posedge dsp_clk);
      #1;
      rst_i = 1'b0;
      check_sen("reset sen", '1, spi_sen_o);
      check_led("reset leds", LED_ACTIVE_LOW, leds_o);
      check_bit("reset rx sel", 1'b0, rx_iq_sel_o);
      check_bit("reset tx sel", 1'b0, tx_iq_sel_o);
      check_bit("reset valid", 1'b0, adc_valid_o);
      check_bit("reset pslverr", 1'b0, pslverr_o);
      check_bit("pready", 1'b1, pready_o);

      for (int i = 0; i < N_REG; i++)
      begin
         apb_write(REG_LEDS, 32'(LED_TAB[i]), err);
         check_bit("leds write err", 1'b0, err);
         apb_write(REG_SPI_SEN, 32'(SEN_TAB[i]), err);
         check_bit("sen write err", 1'b0, err);
         check_led($sformatf("leds pins %0d", i), LED_TAB[i] ^ LED_ACTIVE_LOW, leds_o);
         check_sen($sformatf("sen pins %0d", i), SEN_TAB[i], spi_sen_o);
         apb_read(REG_LEDS, rdata, err);
         check_led($sformatf("leds readback %0d", i), LED_TAB[i], rdata[LED_N-1:0]);
         apb_read(REG_SPI_SEN, rdata, err);
         check_sen($sformatf("sen readback %0d", i), SEN_TAB[i], rdata[SPI_DEV_N-1:0]);
      end

      for (int i = 0; i < N_ERR; i++)
      begin
         if (ERR_WR[i])
            apb_write(ERR_ADDR[i], 32'h0000_3fff, err);
         else
            apb_read(ERR_ADDR[i], rdata, err);
         check_bit($sformatf("pslverr %0d", i), ERR_EXP[i], err);
      end
      // Rejected writes leave the registers alone
      check_led("leds after errors", LED_TAB[N_REG-1] ^ LED_ACTIVE_LOW, leds_o);
      check_sen("sen after errors", SEN_TAB[N_REG-1], spi_sen_o);

      // Parallel ADC, one cycle latency
      for (int i = 0; i < N_PAR; i++)
      begin
         adc_a_pins_i = pin_a[i];
         adc_b_pins_i = pin_b[i];
         next_cycle();
         check_adc($sformatf("par adc a %0d", i), exp_a[i], adc_a_o);
         check_adc($sformatf("par adc b %0d", i), pin_b[i], adc_b_o);
         check_bit("par adc valid", 1'b1, adc_valid_o);
      end
      // Pins held, so the readback pair is stable
      apb_read(REG_ADC_A, rdata, err);
      check_adc("readback a", exp_a[N_PAR-1], rdata[ADC_W-1:0]);
      apb_read(REG_ADC_B, rdata, err);
      check_adc("readback b", pin_b[N_PAR-1], rdata[ADC_W-1:0]);

      for (int i = 0; i < N_PAR; i++)
      begin
         dac_a_i = dac_a_tab[i];
         dac_b_i = dac_b_tab[i];
         next_cycle();
         check_dac($sformatf("par dac a %0d", i), ~dac_b_tab[i], dac_a_o);
         check_dac($sformatf("par dac b %0d", i), dac_a_tab[i], dac_b_o);
         check_dac($sformatf("par lms dac idle %0d", i), '0, dac_sample_t'(lms_dac_o));
      end

      apb_write(REG_CTRL, 32'd1, err);   // IQ mode, phase back to I
      check_bit("ctrl write err", 1'b0, err);
      for (int i = 0; i < N_IQ; i++)
      begin
         lms_adc_i = IQ_I[i];
         next_cycle();
         check_bit("rx sel low", 1'b0, rx_iq_sel_o);
         check_bit("iq valid gap", 1'b0, adc_valid_o);
         lms_adc_i = IQ_Q[i];
         next_cycle();
         check_bit("rx sel high", 1'b1, rx_iq_sel_o);
         check_bit("iq valid", 1'b1, adc_valid_o);
         check_adc($sformatf("iq i %0d", i), {2'b00, IQ_I[i]}, adc_a_o);
         check_adc($sformatf("iq q %0d", i), {2'b00, IQ_Q[i]}, adc_b_o);
      end

      apb_write(REG_CTRL, 32'd1, err);
      check_bit("ctrl rewrite err", 1'b0, err);
      for (int i = 0; i < N_IQ; i++)
      begin
         dac_a_i = dac_a_tab[i];
         dac_b_i = dac_b_tab[i];
         next_cycle();
         check_bit("tx sel low", 1'b0, tx_iq_sel_o);
         check_dac($sformatf("iq dac i %0d", i),
                   dac_sample_t'(dac_a_tab[i][LMS_W-1:0]), dac_sample_t'(lms_dac_o));
         check_dac($sformatf("iq dac a idle %0d", i), '0, dac_a_o);
         check_dac($sformatf("iq dac b idle %0d", i), '0, dac_b_o);
         next_cycle();
         check_bit("tx sel high", 1'b1, tx_iq_sel_o);
         check_dac($sformatf("iq dac q %0d", i),
                   dac_sample_t'(dac_b_tab[i][LMS_W-1:0]), dac_sample_t'(lms_dac_o));
      end

      for (int i = 0; i < N_SPI; i++)
      begin
         apb_write(REG_SPI_SEN, 32'(SPI_SEN_TAB[i]), err);
         spi_miso_i = SPI_MISO_TAB[i];
         for (int k = 0; k < 4; k++)
         begin
            next_cycle();
            sclk_i = k[0];
            mosi_i = ~k[1];
            #1;   // Router is combinational
            check_sen($sformatf("spi sen %0d", i), SPI_SEN_TAB[i], spi_sen_o);
            check_sen($sformatf("spi sclk %0d", i), gated(SPI_SEN_TAB[i], sclk_i), spi_sclk_o);
            check_sen($sformatf("spi mosi %0d", i), gated(SPI_SEN_TAB[i], mosi_i), spi_mosi_o);
            check_bit($sformatf("spi miso %0d", i),
                      miso_sel(SPI_SEN_TAB[i], SPI_MISO_TAB[i]), miso_o);
         end
      end

      $display("Result: PASSED");
      $finish;
   end

endmodule

// File: verilog/fe_top.sv
`timescale 1ns/1ps
// Radio front-end pin adapter

module fe_top (
   input  logic                         dsp_clk,
   input  logic                         rst_i,
   // APB slave
   input  logic [fe_pkg::APB_AW-1:0]    paddr_i,
   input  logic                         psel_i,
   input  logic                         penable_i,
   input  logic                         pwrite_i,
   input  logic [fe_pkg::APB_DW-1:0]    pwdata_i,
   output logic [fe_pkg::APB_DW-1:0]    prdata_o,
   output logic                         pready_o,
   output logic                         pslverr_o,
   output fe_pkg::led_t                 leds_o,
   // ADC side
   input  fe_pkg::adc_sample_t          adc_a_pins_i,
   input  fe_pkg::adc_sample_t          adc_b_pins_i,
   input  logic [fe_pkg::LMS_W-1:0]     lms_adc_i,
   output logic                         rx_iq_sel_o,
   output fe_pkg::adc_sample_t          adc_a_o,
   output fe_pkg::adc_sample_t          adc_b_o,
   output logic                         adc_valid_o,
   // DAC side
   input  fe_pkg::dac_sample_t          dac_a_i,
   input  fe_pkg::dac_sample_t          dac_b_i,
   output fe_pkg::dac_sample_t          dac_a_o,
   output fe_pkg::dac_sample_t          dac_b_o,
   output logic [fe_pkg::LMS_W-1:0]     lms_dac_o,
   output logic                         tx_iq_sel_o,
   // SPI
   input  logic                         sclk_i,
   input  logic                         mosi_i,
   input  logic [fe_pkg::SPI_DEV_N-1:0] spi_miso_i,
   output fe_pkg::spi_sen_t             spi_sen_o,
   output fe_pkg::spi_sen_t             spi_sclk_o,
   output fe_pkg::spi_sen_t             spi_mosi_o,
   output logic                         miso_o
);

   logic mode_wr;   // CTRL write strobe

   fe_cfg_if cfg_if ();

   fe_regs u_regs (
      .dsp_clk   (dsp_clk),
      .rst_i     (rst_i),
      .paddr_i   (paddr_i),
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .pwdata_i  (pwdata_i),
      .prdata_o  (prdata_o),
      .pready_o  (pready_o),
      .pslverr_o (pslverr_o),
      .leds_o    (leds_o),
      .mode_wr_o (mode_wr),
      .cfg       (cfg_if.regs)
   );

   adc_capture u_adc (
      .dsp_clk      (dsp_clk),
      .rst_i        (rst_i),
      .mode_wr_i    (mode_wr),
      .adc_a_pins_i (adc_a_pins_i),
      .adc_b_pins_i (adc_b_pins_i),
      .lms_adc_i    (lms_adc_i),
      .rx_iq_sel_o  (rx_iq_sel_o),
      .cfg          (cfg_if.adc)
   );

   dac_format u_dac (
      .dsp_clk     (dsp_clk),
      .rst_i       (rst_i),
      .mode_wr_i   (mode_wr),
      .dac_a_i     (dac_a_i),
      .dac_b_i     (dac_b_i),
      .dac_a_o     (dac_a_o),
      .dac_b_o     (dac_b_o),
      .lms_dac_o   (lms_dac_o),
      .tx_iq_sel_o (tx_iq_sel_o),
      .cfg         (cfg_if.dac)
   );

   spi_router u_spi (
      .sclk_i     (sclk_i),
      .mosi_i     (mosi_i),
      .spi_miso_i (spi_miso_i),
      .spi_sen_o  (spi_sen_o),
      .spi_sclk_o (spi_sclk_o),
      .spi_mosi_o (spi_mosi_o),
      .miso_o     (miso_o),
      .cfg        (cfg_if.spi)
   );

   // Captured samples on to the DSP core
   assign adc_a_o     = cfg_if.adc_a;
   assign adc_b_o     = cfg_if.adc_b;
   assign adc_valid_o = cfg_if.adc_valid;

endmodule

// File: verilog/spi_router.sv
`timescale 1ns/1ps
// SPI peripheral fan-out

module spi_router (
   input  logic                         sclk_i,
   input  logic                         mosi_i,
   input  logic [fe_pkg::SPI_DEV_N-1:0] spi_miso_i,
   output fe_pkg::spi_sen_t             spi_sen_o,
   output fe_pkg::spi_sen_t             spi_sclk_o,
   output fe_pkg::spi_sen_t             spi_mosi_o,
   output logic                         miso_o,
   fe_cfg_if.spi                        cfg
);
   import fe_pkg::*;

   spi_sen_t active;   // 1 where the select is asserted

   assign active    = ~cfg.spi_sen;
   assign spi_sen_o = cfg.spi_sen;

   // Idle peripherals see clock and data held low
   assign spi_sclk_o = active & {SPI_DEV_N{sclk_i}};
   assign spi_mosi_o = active & {SPI_DEV_N{mosi_i}};

   // Only peripherals with a data-out pin take part
   assign miso_o = |(active & SPI_MISO_MASK & spi_miso_i);

endmodule

// File: verilog/dac_format.sv
`timescale 1ns/1ps
// DAC channel mapping

module dac_format (
   input  logic                     dsp_clk,
   input  logic                     rst_i,
   input  logic                     mode_wr_i,
   input  fe_pkg::dac_sample_t      dac_a_i,
   input  fe_pkg::dac_sample_t      dac_b_i,
   output fe_pkg::dac_sample_t      dac_a_o,
   output fe_pkg::dac_sample_t      dac_b_o,
   output logic [fe_pkg::LMS_W-1:0] lms_dac_o,
   output logic                     tx_iq_sel_o,
   fe_cfg_if.dac                    cfg
);
   import fe_pkg::*;

   logic phase_q;   // 0 sends I (A), 1 sends Q (B)

   always_ff @(posedge dsp_clk)
   begin
      if (rst_i || mode_wr_i)
         phase_q <= 1'b0;
      else if (cfg.mode == FE_MODE_IQ_MUX)
         phase_q <= ~phase_q;
      else
         phase_q <= 1'b0;
   end

   always_ff @(posedge dsp_clk)
   begin
      if (rst_i)
      begin
         dac_a_o     <= '0;
         dac_b_o     <= '0;
         lms_dac_o   <= '0;
         tx_iq_sel_o <= 1'b0;
      end
      else if (cfg.mode == FE_MODE_PARALLEL)
      begin
         // Channels swapped on the board and new A inverted
         dac_a_o     <= ~dac_b_i;
         dac_b_o     <= dac_a_i;
         lms_dac_o   <= '0;
         tx_iq_sel_o <= 1'b0;
      end
      else
      begin
         dac_a_o     <= '0;
         dac_b_o     <= '0;
         lms_dac_o   <= phase_q ? dac_b_i[LMS_W-1:0] : dac_a_i[LMS_W-1:0];
         tx_iq_sel_o <= phase_q;
      end
   end

endmodule

// File: verilog/adc_capture.sv
`timescale 1ns/1ps
// ADC capture and IQ de-interleave

module adc_capture (
   input  logic                     dsp_clk,
   input  logic                     rst_i,
   input  logic                     mode_wr_i,
   input  fe_pkg::adc_sample_t      adc_a_pins_i,
   input  fe_pkg::adc_sample_t      adc_b_pins_i,
   input  logic [fe_pkg::LMS_W-1:0] lms_adc_i,
   output logic                     rx_iq_sel_o,
   fe_cfg_if.adc                    cfg
);
   import fe_pkg::*;

   logic        phase_q;     // 0 = I half, 1 = Q half
   adc_sample_t lms_ext;
   adc_sample_t i_hold_q;
   adc_sample_t adc_a_q;
   adc_sample_t adc_b_q;
   logic        valid_q;

   assign lms_ext = {{(ADC_W - LMS_W){1'b0}}, lms_adc_i};

   always_ff @(posedge dsp_clk)
   begin
      if (rst_i || mode_wr_i)
         phase_q <= 1'b0;
      else if (cfg.mode == FE_MODE_IQ_MUX)
         phase_q <= ~phase_q;
      else
         phase_q <= 1'b0;
   end

   // I sample waits here for its Q partner
   always_ff @(posedge dsp_clk)
   begin
      if (cfg.mode == FE_MODE_IQ_MUX && !phase_q)
         i_hold_q <= lms_ext;
   end

   always_ff @(posedge dsp_clk)
   begin
      if (rst_i)
      begin
         adc_a_q     <= '0;
         adc_b_q     <= '0;
         valid_q     <= 1'b0;
         rx_iq_sel_o <= 1'b0;
      end
      else if (cfg.mode == FE_MODE_PARALLEL)
      begin
         adc_a_q     <= ~adc_a_pins_i;   // A is inverted on the board
         adc_b_q     <= adc_b_pins_i;
         valid_q     <= 1'b1;
         rx_iq_sel_o <= 1'b0;
      end
      else
      begin
         rx_iq_sel_o <= phase_q;
         valid_q     <= phase_q;         // Pair complete on the Q edge
         if (phase_q)
         begin
            adc_a_q <= i_hold_q;
            adc_b_q <= lms_ext;
         end
      end
   end

   assign cfg.adc_a     = adc_a_q;
   assign cfg.adc_b     = adc_b_q;
   assign cfg.adc_valid = valid_q;

endmodule

// File: verilog/fe_regs.sv
`timescale 1ns/1ps
// APB register block and LED driver

module fe_regs (
   input  logic                      dsp_clk,
   input  logic                      rst_i,
   input  logic [fe_pkg::APB_AW-1:0] paddr_i,
   input  logic                      psel_i,
   input  logic                      penable_i,
   input  logic                      pwrite_i,
   input  logic [fe_pkg::APB_DW-1:0] pwdata_i,
   output logic [fe_pkg::APB_DW-1:0] prdata_o,
   output logic                      pready_o,
   output logic                      pslverr_o,
   output fe_pkg::led_t              leds_o,
   output logic                      mode_wr_o,
   fe_cfg_if.regs                    cfg
);
   import fe_pkg::*;

   fe_mode_e    mode_q;
   spi_sen_t    sen_q;
   led_t        led_q;
   adc_sample_t rb_a_q;
   adc_sample_t rb_b_q;

   logic access;
   logic addr_ok;
   logic addr_ro;
   logic wr_en;

   assign access = psel_i & penable_i;   // Access phase
   assign pready_o = 1'b1;                // No wait states

   // Address decode and read mux
   always_comb
   begin
      addr_ok  = 1'b1;
      addr_ro  = 1'b0;
      prdata_o = '0;
      case (paddr_i)
         REG_CTRL:    prdata_o[0] = mode_q;
         REG_SPI_SEN: prdata_o[SPI_DEV_N-1:0] = sen_q;
         REG_LEDS:    prdata_o[LED_N-1:0] = led_q;
         REG_ADC_A:
         begin
            addr_ro = 1'b1;
            prdata_o[ADC_W-1:0] = rb_a_q;
         end
         REG_ADC_B:
         begin
            addr_ro = 1'b1;
            prdata_o[ADC_W-1:0] = rb_b_q;
         end
         default: addr_ok = 1'b0;
      endcase
   end

   assign wr_en     = access & pwrite_i & addr_ok & ~addr_ro;
   assign pslverr_o = access & (~addr_ok | (pwrite_i & addr_ro));
   assign mode_wr_o = wr_en & (paddr_i == REG_CTRL);   // Restarts IQ phase

   always_ff @(posedge dsp_clk)
   begin
      if (rst_i)
      begin
         mode_q <= FE_MODE_PARALLEL;
         sen_q  <= '1;            // Nothing selected
         led_q  <= '0;
      end
      else if (wr_en)
      begin
         case (paddr_i)
            REG_CTRL:    mode_q <= fe_mode_e'(pwdata_i[0]);
            REG_SPI_SEN: sen_q  <= pwdata_i[SPI_DEV_N-1:0];
            REG_LEDS:    led_q  <= pwdata_i[LED_N-1:0];
            default:     ;
         endcase
      end
   end

   // Last captured pair
   always_ff @(posedge dsp_clk)
   begin
      if (cfg.adc_valid)
      begin
         rb_a_q <= cfg.adc_a;
         rb_b_q <= cfg.adc_b;
      end
   end

   assign cfg.mode    = mode_q;
   assign cfg.spi_sen = sen_q;

   // Board LEDs are mostly active low
   assign leds_o = led_q ^ LED_INV_MASK;

endmodule

// File: verilog/fe_cfg_if.sv
`timescale 1ns/1ps
// Front-end configuration and ADC readback

interface fe_cfg_if;
   import fe_pkg::*;

   fe_mode_e    mode;        // From the register block
   spi_sen_t    spi_sen;
   adc_sample_t adc_a;       // From ADC capture
   adc_sample_t adc_b;
   logic        adc_valid;   // One-cycle strobe per new pair

   modport regs (
      output mode,
      output spi_sen,
      input  adc_a,
      input  adc_b,
      input  adc_valid
   );

   modport adc (
      input  mode,
      output adc_a,
      output adc_b,
      output adc_valid
   );

   modport dac (input mode);

   modport spi (input spi_sen);

endinterface

// File: verilog/fe_pkg.sv
// Radio front-end shared definitions

package fe_pkg;

   // Converter widths
   localparam int ADC_W = 14;
   localparam int LMS_W = 12;   // LMS multiplexed buses
   localparam int DAC_W = 16;

   // SPI peripherals, bit order:
   // clk, dac, adc, tx_db, tx_dac, tx_adc, rx_db, rx_dac, rx_adc
   localparam int SPI_DEV_N = 9;

   // Peripherals that drive a data-out line (no adc, tx_dac, rx_dac)
   localparam logic [SPI_DEV_N-1:0] SPI_MISO_MASK = 9'b1_0110_1011;

   // Board LEDs, top bit is the Ethernet LED
   localparam int LED_N = 6;
   localparam logic [LED_N-1:0] LED_INV_MASK = 6'b011111;  // Active-low ones

   // APB slave
   localparam int APB_AW = 8;
   localparam int APB_DW = 32;

   typedef logic [ADC_W-1:0]     adc_sample_t;
   typedef logic [DAC_W-1:0]     dac_sample_t;
   typedef logic [SPI_DEV_N-1:0] spi_sen_t;    // Active-low selects
   typedef logic [LED_N-1:0]     led_t;        // 1 = LED on

   typedef enum logic {
      FE_MODE_PARALLEL = 1'b0,
      FE_MODE_IQ_MUX   = 1'b1
   } fe_mode_e;

   // Register byte addresses
   typedef enum logic [APB_AW-1:0] {
      REG_CTRL    = 8'h00,
      REG_SPI_SEN = 8'h04,
      REG_LEDS    = 8'h08,
      REG_ADC_A   = 8'h0C,   // Read only
      REG_ADC_B   = 8'h10    // Read only
   } fe_reg_e;

endpackage
